// File: include/ldpc_sink_consts.svh
`ifndef LDPC_SINK_CONSTS_SVH
`define LDPC_SINK_CONSTS_SVH

`define LDPC_RADDR_W    8       // Memory word address.
`define LDPC_RDAT_W     2       // Bits per memory word.
`define LDPC_DAT_W      8       // Output byte.
`define LDPC_TAG_W      4       // User tag.
`define LDPC_ERR_W      16      // Decoder error count.
`define LDPC_AXI_AW     8
`define LDPC_AXI_DW     32

// Register map.
`define LDPC_REG_CTRL    8'h00  // Bit 0 is the enable.
`define LDPC_REG_FRAME   8'h04  // Frame length in bytes.
`define LDPC_REG_NFRAMES 8'h08
`define LDPC_REG_NFAIL   8'h0C
`define LDPC_REG_ERRSUM  8'h10
`define LDPC_FRAME_DEF   8'd8   // Frame length out of reset.

`endif

// File: hdl/ldpc_sink_pkg.sv
`include "ldpc_sink_consts.svh"

package ldpc_sink_pkg;

  //--------------------------------------------------------------------
  // Decoder side
  //--------------------------------------------------------------------

  // Per-frame tag, 21 bits.
  typedef struct packed {
    logic                    decfail;  // Decode failed.
    logic [`LDPC_ERR_W-1:0]  err;      // Corrected error count.
    logic [`LDPC_TAG_W-1:0]  tag;      // User tag.
  } dec_tag_t;

  // One word write into the output memory.
  typedef struct packed {
    logic                     val;
    logic [`LDPC_RADDR_W-1:0] addr;
    logic [`LDPC_RDAT_W-1:0]  dat;
  } mem_wr_t;

  //--------------------------------------------------------------------
  // Stream side
  //--------------------------------------------------------------------

  typedef struct packed {
    logic                   sop;  // First byte of frame.
    logic                   eop;  // Last byte of frame.
    logic                   val;
    logic [`LDPC_DAT_W-1:0] dat;
  } out_beat_t;

  // Master to slave channels of AXI4-Lite.
  typedef struct packed {
    logic                       awvalid;
    logic [`LDPC_AXI_AW-1:0]    awaddr;
    logic                       wvalid;
    logic [`LDPC_AXI_DW-1:0]    wdata;
    logic [`LDPC_AXI_DW/8-1:0]  wstrb;
    logic                       bready;
    logic                       arvalid;
    logic [`LDPC_AXI_AW-1:0]    araddr;
    logic                       rready;
  } axil_req_t;

  // Slave to master channels.
  typedef struct packed {
    logic                    awready;
    logic                    wready;
    logic                    bvalid;
    logic [1:0]              bresp;
    logic                    arready;
    logic                    rvalid;
    logic [`LDPC_AXI_DW-1:0] rdata;
    logic [1:0]              rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic [`LDPC_AXI_DW-1:0] nframes;  // Frames delivered.
    logic [`LDPC_AXI_DW-1:0] nfail;    // Frames flagged as failed.
    logic [`LDPC_AXI_DW-1:0] errsum;   // Sum of error counts.
  } sink_stats_t;

endpackage

// File: hdl/ldpc_out_buffer.sv
`timescale 1ns/1ps
`include "ldpc_sink_consts.svh"

module ldpc_out_buffer
  import ldpc_sink_pkg::*;
(
  input  logic                     iclk,
  input  logic                     rst,
  // Decoder write side.
  input  mem_wr_t                  wr,
  input  logic                     frame_done,
  input  dec_tag_t                 done_tag,
  output logic                     wbusy,
  // Sink read side.
  input  logic [`LDPC_RADDR_W-1:0] raddr,
  input  logic                     rempty,
  output logic                     rfull,
  output logic [`LDPC_RDAT_W-1:0]  rdat,
  output dec_tag_t                 rtag
);

  //--------------------------------------------------------------------
  // Storage
  //--------------------------------------------------------------------

  // Both banks in one array, bank select is the top address bit.
  logic [`LDPC_RDAT_W-1:0] mem [2**(`LDPC_RADDR_W+1)];
  dec_tag_t                tag [2];  // Captured per bank on close.

  logic       wbank;  // Bank the decoder fills.
  logic       rbank;  // Oldest bank handed to the sink.
  logic [1:0] full;   // Bank holds a closed frame.

  always_ff @(posedge iclk) begin
    if (wr.val) begin
      mem[{wbank, wr.addr}] <= wr.dat;
    end
    rdat <= mem[{rbank, raddr}];  // One cycle read latency.
  end

  always_ff @(posedge iclk) begin
    if (frame_done) begin
      tag[wbank] <= done_tag;
    end
  end

  //--------------------------------------------------------------------
  // Bank bookkeeping
  //--------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      wbank <= 1'b0;
      rbank <= 1'b0;
      full  <= '0;
    end else begin
      // Free and close never hit the same bank.
      if (rempty) begin
        full[rbank] <= 1'b0;
        rbank       <= ~rbank;
      end
      if (frame_done) begin
        full[wbank] <= 1'b1;
        wbank       <= ~wbank;  // Next frame goes to the other bank.
      end
    end
  end

  assign wbusy = full[wbank];  // Next write bank not drained yet.
  assign rfull = full[rbank];
  assign rtag  = tag[rbank];

  // Decoder must hold off while the sink still owns the next bank.
  a_no_wr_busy : assert property (@(posedge iclk) disable iff (rst)
    wbusy |-> !wr.val && !frame_done)
    else $error("decoder access while wbusy");

  // Sink only frees a bank that it was given.
  a_free_full : assert property (@(posedge iclk) disable iff (rst)
    rempty |-> rfull)
    else $error("rempty on an empty bank");

endmodule

// File: hdl/ldpc_stream_sink.sv
`timescale 1ns/1ps
`include "ldpc_sink_consts.svh"

module ldpc_stream_sink
  import ldpc_sink_pkg::*;
#(
  parameter type tag_t = logic [`LDPC_TAG_W-1:0]
)
(
  input  logic                     iclk,
  input  logic                     rst,
  input  logic                     clkena,
  input  logic [`LDPC_RADDR_W-1:0] frame_bytes,
  input  logic                     rfull,
  input  logic [`LDPC_RDAT_W-1:0]  rdat,
  input  tag_t                     rtag,
  output logic [`LDPC_RADDR_W-1:0] raddr,
  output logic                     rempty,
  input  logic                     req,
  output out_beat_t                dout,
  output tag_t                     otag
);

  localparam int BA_W = `LDPC_RADDR_W - 2;       // Byte index, four words per byte.
  localparam int SH_W = `LDPC_DAT_W - `LDPC_RDAT_W;

  typedef enum logic [1:0] {S_IDLE, S_FILL, S_SEND} state_t;

  state_t                   state;
  logic [`LDPC_DAT_W-1:0]   lbuf [2**BA_W];      // Whole frame, byte wide.
  logic [SH_W-1:0]          sh;                  // First three words of a byte.
  logic [`LDPC_RADDR_W-1:0] wcnt, rd_a, last_w, fb_m1;
  logic                     fetch, rd_v;         // Word issued / word in rdat.
  logic [BA_W-1:0]          last_b, rptr;
  logic                     issue_done, rd_en, xfer;
  out_beat_t                pend, skid, dout_r;  // Read stage, skid, output.
  tag_t                     tag_r;

  assign fb_m1  = frame_bytes - 1'b1;
  assign last_w = {last_b, 2'b11};               // Last word of last byte.
  assign raddr  = clkena ? wcnt : rd_a;          // Hold in-flight word when stalled.
  // Issue only while the output moves, so one skid slot is enough.
  assign rd_en  = (state == S_SEND) && !issue_done && !skid.val && (req || !dout_r.val);
  assign xfer   = dout_r.val && req;

  // Fill path, bits packed LSB first.
  always_ff @(posedge iclk) begin
    if (clkena && state == S_FILL && rd_v) begin
      sh <= {rdat, sh[SH_W-1:`LDPC_RDAT_W]};
      if (rd_a[1:0] == 2'b11) begin
        lbuf[rd_a[`LDPC_RADDR_W-1:2]] <= {rdat, sh};
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (rst) begin
      state      <= S_IDLE;
      wcnt       <= '0;
      rd_a       <= '0;
      fetch      <= 1'b0;
      rd_v       <= 1'b0;
      last_b     <= '0;
      rptr       <= '0;
      issue_done <= 1'b0;
      pend       <= '0;
      skid       <= '0;
      dout_r     <= '0;
      tag_r      <= '0;
      rempty     <= 1'b0;
    end else begin
      rempty <= 1'b0;                            // Single cycle, even when disabled.
      if (clkena) begin
        //--------------------------------------------------------------
        // Frame FSM
        //--------------------------------------------------------------
        case (state)
          S_IDLE: begin
            if (rfull && !rempty) begin          // Skip the bank just freed.
              state      <= S_FILL;
              wcnt       <= '0;
              fetch      <= 1'b1;
              last_b     <= fb_m1[BA_W-1:0];     // Length latched per frame.
              tag_r      <= rtag;
              issue_done <= 1'b0;
            end
          end
          S_FILL: begin
            rd_v <= fetch;
            if (fetch) begin
              rd_a <= wcnt;
              if (wcnt == last_w) fetch <= 1'b0;
              else                wcnt  <= wcnt + 1'b1;
            end
            if (rd_v && rd_a == last_w) begin    // Last byte lands this cycle.
              state <= S_SEND;
              rptr  <= '0;
            end
          end
          S_SEND: begin
            if (rd_en) begin
              if (rptr == last_b) issue_done <= 1'b1;
              else                rptr       <= rptr + 1'b1;
            end
            if (xfer && dout_r.eop) begin
              state  <= S_IDLE;
              rempty <= 1'b1;                    // Hand the bank back.
            end
          end
          default: state <= S_IDLE;
        endcase

        //--------------------------------------------------------------
        // Output pipe
        //--------------------------------------------------------------
        if (rd_en) begin
          pend <= '{sop: (rptr == '0), eop: (rptr == last_b), val: 1'b1, dat: lbuf[rptr]};
        end else begin
          pend <= '0;
        end
        if (!dout_r.val || req) begin
          if (skid.val) begin
            dout_r <= skid;                      // Drain skid first.
            skid   <= pend;
          end else begin
            dout_r <= pend;
          end
        end else if (pend.val) begin
          skid <= pend;                          // Output blocked, park the byte.
        end
      end
    end
  end

  assign dout = '{sop: dout_r.sop, eop: dout_r.eop, val: dout_r.val & clkena, dat: dout_r.dat};
  assign otag = tag_r;

  // A stalled beat and its tag hold until taken.
  a_hold_beat : assert property (@(posedge iclk) disable iff (rst)
    (dout.val && !req) |=> $stable(dout_r) && $stable(otag))
    else $error("output beat changed under back-pressure");

endmodule

// File: hdl/ldpc_dec_sink.sv
`timescale 1ns/1ps
`include "ldpc_sink_consts.svh"

module ldpc_dec_sink
  import ldpc_sink_pkg::*;
(
  input  logic                     iclk,
  input  logic                     rst,
  input  logic                     clkena,
  input  logic [`LDPC_RADDR_W-1:0] frame_bytes,
  // Output memory.
  input  logic                     rfull,
  input  logic [`LDPC_RDAT_W-1:0]  rdat,
  input  dec_tag_t                 rtag,
  output logic [`LDPC_RADDR_W-1:0] raddr,
  output logic                     rempty,
  // Byte stream.
  input  logic                     req,
  output out_beat_t                dout,
  output dec_tag_t                 otag,
  output sink_stats_t              stats
);

  logic eop_xfer;  // Last byte of a frame taken.

  // Generic reader carrying the full decoder tag.
  ldpc_stream_sink #(
    .tag_t       (dec_tag_t)
  ) u_sink (
    .iclk        (iclk),
    .rst         (rst),
    .clkena      (clkena),
    .frame_bytes (frame_bytes),
    .rfull       (rfull),
    .rdat        (rdat),
    .rtag        (rtag),
    .raddr       (raddr),
    .rempty      (rempty),
    .req         (req),
    .dout        (dout),
    .otag        (otag)
  );

  assign eop_xfer = dout.val && dout.eop && req;  // val already gated by clkena.

  // Totals, one update per delivered frame.
  always_ff @(posedge iclk) begin
    if (rst) begin
      stats <= '0;
    end else if (eop_xfer) begin
      stats.nframes <= stats.nframes + 1'b1;
      stats.errsum  <= stats.errsum + {{(`LDPC_AXI_DW-`LDPC_ERR_W){1'b0}}, otag.err};
      if (otag.decfail) begin
        stats.nfail <= stats.nfail + 1'b1;
      end
    end
  end

endmodule

// File: hdl/ldpc_sink_regs.sv
`timescale 1ns/1ps
`include "ldpc_sink_consts.svh"

module ldpc_sink_regs
  import ldpc_sink_pkg::*;
(
  input  logic                     iclk,
  input  logic                     rst,
  input  axil_req_t                axi_req,
  output axil_rsp_t                axi_rsp,
  output logic                     clkena,
  output logic [`LDPC_RADDR_W-1:0] frame_bytes,
  input  sink_stats_t              stats
);

  logic                     wr_rdy, bvalid;  // AW/W ready pulse, write response.
  logic                     rd_rdy, rvalid;
  logic                     wr_acc, rd_acc;
  logic [`LDPC_AXI_DW-1:0]  rdata, rd_mux;
  logic                     en_r;
  logic [`LDPC_RADDR_W-1:0] frame_r;

  // Handshakes.
  assign wr_acc = axi_req.awvalid && axi_req.wvalid && wr_rdy;
  assign rd_acc = axi_req.arvalid && rd_rdy;

  //--------------------------------------------------------------------
  // Read decode
  //--------------------------------------------------------------------

  always_comb begin
    rd_mux = '0;  // Unknown offsets read zero.
    case (axi_req.araddr)
      `LDPC_REG_CTRL:    rd_mux[0] = en_r;
      `LDPC_REG_FRAME:   rd_mux[`LDPC_RADDR_W-1:0] = frame_r;
      `LDPC_REG_NFRAMES: rd_mux = stats.nframes;
      `LDPC_REG_NFAIL:   rd_mux = stats.nfail;
      `LDPC_REG_ERRSUM:  rd_mux = stats.errsum;
      default:           rd_mux = '0;
    endcase
  end

  //--------------------------------------------------------------------
  // Channel control and registers
  //--------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      wr_rdy  <= 1'b0;
      bvalid  <= 1'b0;
      rd_rdy  <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
      en_r    <= 1'b1;             // Sink runs out of reset.
      frame_r <= `LDPC_FRAME_DEF;
    end else begin
      // Take AW and W together, one at a time.
      wr_rdy <= axi_req.awvalid && axi_req.wvalid && !wr_rdy && !bvalid;
      if (wr_acc) begin
        bvalid <= 1'b1;            // OKAY for every address.
        if (axi_req.wstrb[0]) begin
          case (axi_req.awaddr)
            `LDPC_REG_CTRL:  en_r    <= axi_req.wdata[0];
            `LDPC_REG_FRAME: frame_r <= axi_req.wdata[`LDPC_RADDR_W-1:0];
            default: ;             // Totals and holes ignore writes.
          endcase
        end
      end else if (bvalid && axi_req.bready) begin
        bvalid <= 1'b0;
      end

      rd_rdy <= axi_req.arvalid && !rd_rdy && !rvalid;
      if (rd_acc) begin
        rvalid <= 1'b1;
        rdata  <= rd_mux;          // Sampled at AR acceptance.
      end else if (rvalid && axi_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  assign axi_rsp = '{awready: wr_rdy, wready: wr_rdy, bvalid: bvalid, bresp: 2'b00,
                     arready: rd_rdy, rvalid: rvalid, rdata: rdata, rresp: 2'b00};

  assign clkena      = en_r;
  assign frame_bytes = frame_r;

  // Every B response belongs to a write taken the cycle before.
  a_b_after_w : assert property (@(posedge iclk) disable iff (rst)
    $rose(bvalid) |-> $past(wr_acc))
    else $error("bvalid without accepted write");

endmodule

// File: hdl/ldpc_dec_out_top.sv
`timescale 1ns/1ps
`include "ldpc_sink_consts.svh"

module ldpc_dec_out_top
  import ldpc_sink_pkg::*;
(
  input  logic      iclk,
  input  logic      rst,
  // Decoder.
  input  mem_wr_t   wr,
  input  logic      frame_done,
  input  dec_tag_t  done_tag,
  output logic      wbusy,
  // Byte stream.
  input  logic      req,
  output out_beat_t dout,
  output dec_tag_t  otag,
  // Control bus.
  input  axil_req_t axi_req,
  output axil_rsp_t axi_rsp
);

  logic [`LDPC_RADDR_W-1:0] raddr, frame_bytes;
  logic [`LDPC_RDAT_W-1:0]  rdat;
  logic                     rempty, rfull, clkena;
  dec_tag_t                 rtag;
  sink_stats_t              stats;

  ldpc_out_buffer u_buf (
    .iclk (iclk), .rst (rst),
    .wr (wr), .frame_done (frame_done), .done_tag (done_tag), .wbusy (wbusy),
    .raddr (raddr), .rempty (rempty), .rfull (rfull), .rdat (rdat), .rtag (rtag)
  );

  ldpc_dec_sink u_sink (
    .iclk (iclk), .rst (rst), .clkena (clkena), .frame_bytes (frame_bytes),
    .rfull (rfull), .rdat (rdat), .rtag (rtag), .raddr (raddr), .rempty (rempty),
    .req (req), .dout (dout), .otag (otag), .stats (stats)
  );

  ldpc_sink_regs u_regs (
    .iclk        (iclk),
    .rst         (rst),
    .axi_req     (axi_req),
    .axi_rsp     (axi_rsp),
    .clkena      (clkena),
    .frame_bytes (frame_bytes),
    .stats       (stats)
  );

endmodule

// File: sim/tb_ldpc_dec_out.sv
`timescale 1ns/1ps
`include "ldpc_sink_consts.svh"

module tb_ldpc_dec_out
  import ldpc_sink_pkg::*;
();

  localparam int TMO = 4000;  // Cycles allowed for any single wait.

  typedef logic [`LDPC_RDAT_W-1:0] word_list_t [2**`LDPC_RADDR_W];

  logic        iclk = 1'b0;
  logic        rst;
  mem_wr_t     wr;
  logic        frame_done;
  dec_tag_t    done_tag;
  logic        wbusy;
  logic        req;
  out_beat_t   dout;
  dec_tag_t    otag;
  axil_req_t   axi_req;
  axil_rsp_t   axi_rsp;

  integer      seed;                     // Frame data and tags.
  integer      req_seed;                 // Back-pressure pattern.
  logic [31:0] req_rnd;
  int          req_mode;                 // 0 hold low, 1 hold high, 2 random.
  int          n_mis, n_oth, n_beats, beats_before;
  out_beat_t   exp_beat [$];             // Expected bytes, oldest first.
  dec_tag_t    exp_tag [$];
  logic [31:0] sent_frames, sent_fail, sent_err;  // Totals from the model.

  ldpc_dec_out_top DUT (
    .iclk       (iclk),
    .rst        (rst),
    .wr         (wr),
    .frame_done (frame_done),
    .done_tag   (done_tag),
    .wbusy      (wbusy),
    .req        (req),
    .dout       (dout),
    .otag       (otag),
    .axi_req    (axi_req),
    .axi_rsp    (axi_rsp)
  );

  always #4 iclk = ~iclk;  // 8 ns period.

  // Downstream ready, changed 1 ns after the edge.
  initial begin
    req = 1'b0;
    forever begin
      @(posedge iclk);
      #1;
      case (req_mode)
        0:       req = 1'b0;
        1:       req = 1'b1;
        default: begin
          req_rnd = $random(req_seed);
          req     = req_rnd[0];
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------------------------------------

  // Byte k takes words 4k..4k+3, first word in the low bits.
  function automatic logic [`LDPC_DAT_W-1:0] pack_byte(input word_list_t w, input int k);
    logic [`LDPC_DAT_W-1:0] b;
    int                     i;
    for (i = 0; i < 4; i++) begin
      b[`LDPC_RDAT_W*i +: `LDPC_RDAT_W] = w[4*k + i];
    end
    return b;
  endfunction

  task automatic check_beat(input out_beat_t got, input out_beat_t exp);
    if (got !== exp) begin
      $display("Mismatch dout {sop,eop,val,dat}: got %h expected %h", got, exp);
      n_mis++;
    end
  endtask

  task automatic check_tag(input dec_tag_t got, input dec_tag_t exp);
    if (got !== exp) begin
      $display("Mismatch otag {decfail,err,tag}: got %h expected %h", got, exp);
      n_mis++;
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      n_mis++;
    end
  endtask

  // A beat valid with req high at the falling edge transfers on the next rise.
  always @(negedge iclk) begin
    if (!rst && dout.val && req) begin
      n_beats++;
      if (exp_beat.size() == 0) begin
        $display("Unexpected byte %h delivered with no frame pending", dout.dat);
        n_oth++;
      end else begin
        check_beat(dout, exp_beat.pop_front());
        check_tag(otag, exp_tag.pop_front());
      end
    end
  end

  // ----------------------------------------------------------------------
  // AXI4-Lite master
  // ----------------------------------------------------------------------

  task automatic axi_write(input logic [`LDPC_AXI_AW-1:0] addr, input logic [31:0] data);
    int n;
    @(posedge iclk);
    #1;
    axi_req.awvalid = 1'b1;
    axi_req.awaddr  = addr;
    axi_req.wvalid  = 1'b1;
    axi_req.wdata   = data;
    axi_req.wstrb   = '1;
    n = 0;
    @(negedge iclk);
    while (!(axi_rsp.awready && axi_rsp.wready) && n < TMO) begin
      @(negedge iclk);
      n++;
    end
    if (!(axi_rsp.awready && axi_rsp.wready)) begin
      $display("AXI write to %h was never accepted", addr);
      n_oth++;
    end
    @(posedge iclk);                    // AW and W taken here.
    #1;
    axi_req.awvalid = 1'b0;
    axi_req.wvalid  = 1'b0;
    n = 0;
    @(negedge iclk);
    while (!axi_rsp.bvalid && n < TMO) begin
      @(negedge iclk);
      n++;
    end
    if (!axi_rsp.bvalid) begin
      $display("No write response for address %h", addr);
      n_oth++;
    end else begin
      check_reg("bresp", {30'b0, axi_rsp.bresp}, 32'h0);
    end
    @(posedge iclk);                    // bready is always high.
  endtask

  task automatic axi_read(input logic [`LDPC_AXI_AW-1:0] addr, output logic [31:0] data);
    int n;
    data = 'x;
    @(posedge iclk);
    #1;
    axi_req.arvalid = 1'b1;
    axi_req.araddr  = addr;
    n = 0;
    @(negedge iclk);
    while (!axi_rsp.arready && n < TMO) begin
      @(negedge iclk);
      n++;
    end
    if (!axi_rsp.arready) begin
      $display("AXI read of %h was never accepted", addr);
      n_oth++;
    end
    @(posedge iclk);
    #1;
    axi_req.arvalid = 1'b0;
    n = 0;
    @(negedge iclk);
    while (!axi_rsp.rvalid && n < TMO) begin
      @(negedge iclk);
      n++;
    end
    if (!axi_rsp.rvalid) begin
      $display("No read data for address %h", addr);
      n_oth++;
    end else begin
      check_reg("rresp", {30'b0, axi_rsp.rresp}, 32'h0);
      data = axi_rsp.rdata;
    end
    @(posedge iclk);
  endtask

  task automatic read_expect(input string name, input logic [`LDPC_AXI_AW-1:0] addr,
                             input logic [31:0] exp);
    logic [31:0] data;
    axi_read(addr, data);
    check_reg(name, data, exp);
  endtask

  task automatic check_stats();
    read_expect("NFRAMES", `LDPC_REG_NFRAMES, sent_frames);
    read_expect("NFAIL", `LDPC_REG_NFAIL, sent_fail);
    read_expect("ERRSUM", `LDPC_REG_ERRSUM, sent_err);
  endtask

  // ----------------------------------------------------------------------
  // Decoder model and waits
  // ----------------------------------------------------------------------

  task automatic send_frame(input int nbytes);
    word_list_t  w;
    dec_tag_t    t;
    out_beat_t   beat;
    logic [31:0] r;
    int          i;
    int          n;
    n = 0;
    @(negedge iclk);
    while (wbusy && n < TMO) begin
      @(negedge iclk);
      n++;
    end
    if (wbusy) begin
      $display("Timeout waiting for a free bank, frame dropped");
      n_oth++;
      return;
    end
    r = $random(seed);
    t = '{decfail: r[20], err: r[19:4], tag: r[3:0]};
    for (i = 0; i < 4 * nbytes; i++) begin
      r    = $random(seed);
      w[i] = r[`LDPC_RDAT_W-1:0];
    end
    for (i = 0; i < nbytes; i++) begin
      beat.sop = (i == 0);
      beat.eop = (i == nbytes - 1);
      beat.val = 1'b1;
      beat.dat = pack_byte(w, i);
      exp_beat.push_back(beat);
      exp_tag.push_back(t);                  // Same tag on every byte.
    end
    sent_frames = sent_frames + 32'd1;
    sent_fail   = sent_fail + {31'b0, t.decfail};
    sent_err    = sent_err + {16'b0, t.err};
    // Highest address first.
    for (i = 4 * nbytes - 1; i >= 0; i--) begin
      @(posedge iclk);
      #1;
      wr = '{val: 1'b1, addr: i[`LDPC_RADDR_W-1:0], dat: w[i]};
    end
    @(posedge iclk);
    #1;
    wr         = '0;
    frame_done = 1'b1;                      // Close bank, hand over tag.
    done_tag   = t;
    @(posedge iclk);
    #1;
    frame_done = 1'b0;
  endtask

  task automatic wait_wbusy(input logic level);
    int n;
    n = 0;
    @(negedge iclk);
    while (wbusy !== level && n < TMO) begin
      @(negedge iclk);
      n++;
    end
    if (wbusy !== level) begin
      $display("Timeout waiting for wbusy to become %0d", level);
      n_oth++;
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    @(negedge iclk);
    while (exp_beat.size() != 0 && n < TMO) begin
      @(negedge iclk);
      n++;
    end
    if (exp_beat.size() != 0) begin
      $display("Timeout with %0d bytes still undelivered", exp_beat.size());
      n_oth++;
      exp_beat.delete();
      exp_tag.delete();
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    seed           = 34;
    req_seed       = seed + 1;
    req_mode       = 1;
    rst            = 1'b1;
    wr             = '0;
    frame_done     = 1'b0;
    done_tag       = '0;
    axi_req        = '0;
    axi_req.bready = 1'b1;
    axi_req.rready = 1'b1;
    n_mis          = 0;
    n_oth          = 0;
    n_beats        = 0;
    sent_frames    = '0;
    sent_fail      = '0;
    sent_err       = '0;
    repeat (8) @(posedge iclk);
    #1;
    rst = 1'b0;

    // Defaults, readback, totals clear.
    read_expect("CTRL", `LDPC_REG_CTRL, 32'd1);
    read_expect("FRAME", `LDPC_REG_FRAME, 32'd8);
    check_stats();
    axi_write(`LDPC_REG_FRAME, 32'd16);
    read_expect("FRAME", `LDPC_REG_FRAME, 32'd16);
    axi_write(`LDPC_REG_NFRAMES, 32'hffff_ffff);  // Read only.
    check_stats();

    // Full rate, both lengths.
    repeat (3) send_frame(16);
    wait_drained();
    axi_write(`LDPC_REG_FRAME, 32'd8);
    read_expect("FRAME", `LDPC_REG_FRAME, 32'd8);
    repeat (3) send_frame(8);
    wait_drained();

    // Random back-pressure.
    req_mode = 2;
    repeat (4) send_frame(8);
    wait_drained();
    axi_write(`LDPC_REG_FRAME, 32'd16);
    repeat (4) send_frame(16);
    wait_drained();
    check_stats();

    // Stalled output, both banks fill.
    req_mode = 0;
    send_frame(16);
    send_frame(16);
    wait_wbusy(1'b1);
    req_mode = 1;
    wait_wbusy(1'b0);                        // First bank freed.
    send_frame(16);
    wait_drained();

    // Sink disabled, nothing may move.
    axi_write(`LDPC_REG_CTRL, 32'd0);
    beats_before = n_beats;
    send_frame(16);
    repeat (100) @(negedge iclk);
    if (n_beats != beats_before) begin
      $display("%0d bytes were transferred while the sink was disabled",
               n_beats - beats_before);
      n_oth++;
    end
    axi_write(`LDPC_REG_CTRL, 32'd1);
    wait_drained();
    check_stats();

    $display("Checked %0d beats, %0d mismatches, %0d other errors", n_beats, n_mis, n_oth);
    if (n_mis == 0 && n_oth == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
hdl/ldpc_sink_pkg.sv
hdl/ldpc_out_buffer.sv
hdl/ldpc_stream_sink.sv
hdl/ldpc_dec_sink.sv
hdl/ldpc_sink_regs.sv
hdl/ldpc_dec_out_top.sv
sim/tb_ldpc_dec_out.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  -f tb.f --top-module tb_ldpc_dec_out -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
  exit 0
fi
exit 1
